// ==== bench/fpu_int_clk_gen.sv ====
// 20 ns clock, reset low for the first 5 rising edges
`timescale 1ns/10ps
`default_nettype none

module fpu_int_clk_gen (
  output logic clk_o,
  output logic rst_n_o
);

  initial begin
    clk_o = 1'b0;
    forever #10 clk_o = ~clk_o;
  end

  initial begin
    rst_n_o = 1'b0;
    repeat (5) @(posedge clk_o);
    rst_n_o <= 1'b1;
  end

endmodule

`default_nettype wire

// ==== bench/fpu_int_props.sv ====
// Control timing checks for fpu_int_top attached by bind from the testbench
// Longest conversion of 32 shift steps brings done 36 edges after start
`timescale 1ns/10ps
`default_nettype none

module fpu_int_props (
  input logic                        clk_i,
  input logic                        rst_n_i,
  input logic                        start_i,
  input fpu_int_op_pkg::fpu_int_op_e op_i,
  input logic                        busy_i,
  input logic                        done_i
);

  logic accept;
  logic is_cvt;
  int   fail_count = 0;

  assign accept = start_i && !busy_i;
  assign is_cvt = (op_i == fpu_int_op_pkg::FCVT_W) || (op_i == fpu_int_op_pkg::FCVT_WU);

  // First edge out of reset
  assert property (@(posedge clk_i) $rose(rst_n_i) |-> !busy_i && !done_i)
    else begin
      $error("busy or done high right after reset");
      fail_count++;
    end

  assert property (@(posedge clk_i) disable iff (!rst_n_i) done_i |=> !done_i)
    else begin
      $error("done held high for more than one cycle");
      fail_count++;
    end

  // Latch cycle then result register and done
  assert property (@(posedge clk_i) disable iff (!rst_n_i)
    accept && !is_cvt |-> ##1 !done_i ##1 done_i)
    else begin
      $error("non-convert done not exactly two cycles after start");
      fail_count++;
    end

  assert property (@(posedge clk_i) disable iff (!rst_n_i) accept |-> ##[2:36] done_i)
    else begin
      $error("done missing within 36 cycles of start");
      fail_count++;
    end

endmodule

`default_nettype wire

// ==== bench/fpu_int_tb.sv ====
// Run from the project root
// Directed cases come from bench/fpu_int_vectors.txt
// Random FMV and FEQ self cases use a fixed xorshift seed
`timescale 1ns/10ps
`default_nettype none

`include "fpu_int_macros.svh"

module fpu_int_tb;

  localparam int MAX_VEC       = 80;
  localparam int VEC_WORDS     = 6;
  localparam int DONE_TIMEOUT  = 50;
  localparam int RESET_TIMEOUT = 20;
  localparam int RAND_CASES    = 24;
  localparam fpu_int_op_pkg::fflags_t FLAG_NV = 5'b1 << `FPU_INT_NV;
  localparam fpu_int_op_pkg::fflags_t FLAG_NX = 5'b1 << `FPU_INT_NX;

  logic                        clk;
  logic                        rst_n;
  logic                        start;
  fpu_int_op_pkg::fpu_int_op_e op;
  fpu_int_op_pkg::frm_e        rm;
  fpu_fmt_pkg::fp_word_t       rs1;
  fpu_fmt_pkg::fp_word_t       rs2;
  logic                        busy;
  logic                        done;
  fpu_fmt_pkg::int_word_t      result;
  fpu_int_op_pkg::fflags_t     fflags;

  // Six words per case as op rm rs1 rs2 result flags
  logic [31:0] vec_mem [0:MAX_VEC*VEC_WORDS-1];
  int checks;
  int mismatches;
  int failures;

  fpu_int_clk_gen clk_gen_i (.clk_o (clk), .rst_n_o (rst_n));

  fpu_int_top fpu_int_top_i (
    .clk_i    (clk),
    .rst_n_i  (rst_n),
    .start_i  (start),
    .op_i     (op),
    .rm_i     (rm),
    .rs1_i    (rs1),
    .rs2_i    (rs2),
    .busy_o   (busy),
    .done_o   (done),
    .result_o (result),
    .fflags_o (fflags)
  );

  bind fpu_int_top fpu_int_props props_i (
    .clk_i   (clk_i),
    .rst_n_i (rst_n_i),
    .start_i (start_i),
    .op_i    (op_i),
    .busy_i  (busy_o),
    .done_i  (done_o)
  );

  function automatic logic [31:0] xorshift32(input logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
  endfunction

  // All-ones exponent with a nonzero fraction
  function automatic bit is_nan(input logic [31:0] x);
    return (x[30:23] == 8'hff) && (x[22:0] != '0);
  endfunction

  function automatic bit signaling_nan(input logic [31:0] x);
    return is_nan(x) && !x[22];
  endfunction

  task automatic wait_done(input string name, output bit seen);
    int waited;
    waited = 0;
    seen = 1'b0;
    while (!seen && waited < DONE_TIMEOUT) begin
      @(posedge clk);
      seen = done;
      waited++;
    end
    if (!seen) begin
      $display("done never came for %s", name);
      failures++;
    end
  endtask

  task automatic compare_outputs(input string name, input logic [31:0] exp_res,
                                 input fpu_int_op_pkg::fflags_t exp_flags);
    checks++;
    assert (result === exp_res) else begin
      $display("mismatch %s result expected %h actual %h", name, exp_res, result);
      mismatches++;
    end
    assert (fflags === exp_flags) else begin
      $display("mismatch %s fflags expected %b actual %b", name, exp_flags, fflags);
      mismatches++;
    end
  endtask

  task automatic run_op(input fpu_int_op_pkg::fpu_int_op_e op_code,
                        input fpu_int_op_pkg::frm_e rm_code,
                        input logic [31:0] a, input logic [31:0] b, input string name,
                        input logic [31:0] exp_res, input fpu_int_op_pkg::fflags_t exp_flags);
    bit seen;
    @(posedge clk);
    start <= 1'b1;
    op    <= op_code;
    rm    <= rm_code;
    rs1   <= a;
    rs2   <= b;
    @(posedge clk);
    start <= 1'b0;
    wait_done(name, seen);
    if (seen) begin
      compare_outputs(name, exp_res, exp_flags);
    end
  endtask

  // Second start lands mid conversion and must leave no trace
  task automatic busy_start_test();
    bit seen;
    int pulses;
    @(posedge clk);
    start <= 1'b1;
    op    <= fpu_int_op_pkg::FCVT_W;
    rm    <= fpu_int_op_pkg::RUP;
    rs1   <= 32'h4020_0000;
    rs2   <= '0;
    @(posedge clk);
    start <= 1'b0;
    @(posedge clk);
    assert (busy === 1'b1) else begin
      $display("busy was low while a conversion was running");
      failures++;
    end
    start <= 1'b1;
    op    <= fpu_int_op_pkg::FMV;
    rs1   <= 32'h1234_5678;
    @(posedge clk);
    start <= 1'b0;
    wait_done("busy start", seen);
    pulses = seen ? 1 : 0;
    repeat (40) begin
      @(posedge clk);
      if (done) begin
        pulses++;
      end
    end
    assert (pulses == 1) else begin
      $display("mismatch busy start done pulses expected 1 actual %0d", pulses);
      mismatches++;
    end
    if (seen) begin
      compare_outputs("busy start", 32'd3, FLAG_NX);
    end
  endtask

  initial begin
    int idx;
    int base;
    int waited;
    logic [31:0] rnd;
    logic [31:0] operand;
    start      = 1'b0;
    op         = fpu_int_op_pkg::FEQ;
    rm         = fpu_int_op_pkg::RNE;
    rs1        = '0;
    rs2        = '0;
    checks     = 0;
    mismatches = 0;
    failures   = 0;

    // Op word above 6 marks the end of the list
    for (idx = 0; idx < MAX_VEC*VEC_WORDS; idx++) begin
      vec_mem[idx] = 32'hffff_0000 | 32'(idx);
    end
    $readmemh("bench/fpu_int_vectors.txt", vec_mem);

    waited = 0;
    while (rst_n !== 1'b1 && waited < RESET_TIMEOUT) begin
      @(posedge clk);
      waited++;
    end
    if (rst_n !== 1'b1) begin
      $display("reset was never released");
      failures++;
    end
    @(posedge clk);
    assert (busy === 1'b0 && done === 1'b0 && result === '0 && fflags === '0) else begin
      $display("outputs were not cleared by reset");
      failures++;
    end

    idx = 0;
    while (idx < MAX_VEC && vec_mem[idx*VEC_WORDS] <= 32'd6) begin
      base = idx * VEC_WORDS;
      run_op(fpu_int_op_pkg::fpu_int_op_e'(vec_mem[base][2:0]),
             fpu_int_op_pkg::frm_e'(vec_mem[base+1][2:0]),
             vec_mem[base+2], vec_mem[base+3], $sformatf("vector %0d", idx),
             vec_mem[base+4], vec_mem[base+5][4:0]);
      idx++;
    end
    if (idx == 0) begin
      $display("the vectors file held no cases");
      failures++;
    end

    rnd = 32'd22990;
    for (idx = 0; idx < RAND_CASES; idx++) begin
      rnd = xorshift32(rnd);
      // Every fourth operand gets an all-ones exponent for NaN and infinity
      operand = (idx % 4 == 3) ? (rnd | 32'h7f80_0000) : rnd;
      run_op(fpu_int_op_pkg::FMV, fpu_int_op_pkg::RNE, operand, 32'h0,
             $sformatf("fmv random %0d", idx), operand, '0);
      run_op(fpu_int_op_pkg::FEQ, fpu_int_op_pkg::RNE, operand, operand,
             $sformatf("feq self random %0d", idx), {31'd0, !is_nan(operand)},
             signaling_nan(operand) ? FLAG_NV : '0);
    end

    busy_start_test();

    $display("checks %0d, mismatches %0d, other failures %0d, assertion failures %0d",
             checks, mismatches, failures, fpu_int_top_i.props_i.fail_count);
    if (mismatches == 0 && failures == 0 && fpu_int_top_i.props_i.fail_count == 0) begin
      $display("Simulation finished: PASS");
    end else begin
      $display("Simulation finished: FAIL");
    end
    $finish;
  end

endmodule

`default_nettype wire

// ==== bench/fpu_int_vectors.txt ====
// op rm rs1 rs2 expected_result expected_flags, all hex, flags 10 is NV and 01 is NX
// op 0 FEQ 1 FLT 2 FLE 3 FCVT_W 4 FCVT_WU 5 FCLASS 6 FMV, rm 0 RNE 1 RTZ 2 RDN 3 RUP 4 RMM
5 0 ff800000 00000000 00000001 00
5 0 bf800000 00000000 00000002 00
5 0 80000001 00000000 00000004 00
5 0 80000000 00000000 00000008 00
5 0 00000000 00000000 00000010 00
5 0 00000001 00000000 00000020 00
5 0 3f800000 00000000 00000040 00
5 0 7f800000 00000000 00000080 00
5 0 7f800001 00000000 00000100 00
5 0 7fc00000 00000000 00000200 00
// Comparisons
0 0 3f800000 3f800000 00000001 00
0 0 00000000 80000000 00000001 00
1 0 80000000 00000000 00000000 00
2 0 80000000 00000000 00000001 00
1 0 3f800000 40000000 00000001 00
1 0 c0000000 bf800000 00000001 00
2 0 40000000 3f800000 00000000 00
0 0 7fc00000 3f800000 00000000 00
1 0 7fc00000 3f800000 00000000 10
2 0 3f800000 7fc00000 00000000 10
0 0 7f800001 3f800000 00000000 10
// FCVT_W of 2.5, -2.5, 1.5, -1.5 and 0.3 in each rounding mode
3 0 40200000 00000000 00000002 01
3 1 40200000 00000000 00000002 01
3 2 40200000 00000000 00000002 01
3 3 40200000 00000000 00000003 01
3 4 40200000 00000000 00000003 01
3 0 c0200000 00000000 fffffffe 01
3 1 c0200000 00000000 fffffffe 01
3 2 c0200000 00000000 fffffffd 01
3 3 c0200000 00000000 fffffffe 01
3 4 c0200000 00000000 fffffffd 01
3 0 3fc00000 00000000 00000002 01
3 1 3fc00000 00000000 00000001 01
3 2 3fc00000 00000000 00000001 01
3 3 3fc00000 00000000 00000002 01
3 4 3fc00000 00000000 00000002 01
3 0 bfc00000 00000000 fffffffe 01
3 1 bfc00000 00000000 ffffffff 01
3 2 bfc00000 00000000 fffffffe 01
3 3 bfc00000 00000000 ffffffff 01
3 4 bfc00000 00000000 fffffffe 01
3 0 3e99999a 00000000 00000000 01
3 1 3e99999a 00000000 00000000 01
3 2 3e99999a 00000000 00000000 01
3 3 3e99999a 00000000 00000001 01
3 4 3e99999a 00000000 00000000 01
3 0 3f800000 00000000 00000001 00
3 0 4e800000 00000000 40000000 00
3 3 00000001 00000000 00000001 01
4 0 40200000 00000000 00000002 01
4 4 3fc00000 00000000 00000002 01
4 1 be99999a 00000000 00000000 01
// Saturation
3 0 7fc00000 00000000 7fffffff 10
3 0 7f800000 00000000 7fffffff 10
3 0 ff800000 00000000 80000000 10
3 0 4f000000 00000000 7fffffff 10
4 0 7fc00000 00000000 ffffffff 10
4 0 7f800000 00000000 ffffffff 10
4 0 ff800000 00000000 00000000 10
4 0 4f000000 00000000 ffffffff 10
4 0 bf800000 00000000 00000000 10
6 0 7fc00001 3f800000 7fc00001 00

// ==== compile.f ====
+incdir+hdl
hdl/fpu_fmt_pkg.sv
hdl/fpu_int_op_pkg.sv
hdl/fpu_int_classify.sv
hdl/fpu_int_compare.sv
hdl/fpu_int_step_counter.sv
hdl/fpu_int_f2i.sv
hdl/fpu_int_ctrl.sv
hdl/fpu_int_top.sv
bench/fpu_int_clk_gen.sv
bench/fpu_int_props.sv
bench/fpu_int_tb.sv

// ==== hdl/fpu_fmt_pkg.sv ====
// Plain binary32 field types, no recoded format anywhere
`default_nettype none

`include "fpu_int_macros.svh"

package fpu_fmt_pkg;

  // Whole operand
  typedef logic [`FPU_INT_XLEN-1:0] fp_word_t;

  // Biased exponent and stored fraction
  typedef logic [`FPU_INT_EXP_BITS-1:0] fp_exp_t;
  typedef logic [`FPU_INT_MANT_BITS-1:0] fp_mant_t;

  // Integer writeback word
  typedef logic [`FPU_INT_XLEN-1:0] int_word_t;

  // FCLASS mask, bit 0 is negative infinity, bit 9 is quiet NaN
  typedef logic [9:0] fclass_t;

  // Remaining right-shift steps of a conversion
  typedef logic [`FPU_INT_CNT_BITS-1:0] shift_cnt_t;

endpackage

`default_nettype wire

// ==== hdl/fpu_int_classify.sv ====
// FCLASS.S decode, purely combinational
`timescale 1ns/10ps
`default_nettype none

`include "fpu_int_macros.svh"

module fpu_int_classify (
  input  fpu_fmt_pkg::fp_word_t rs1_i,
  output fpu_fmt_pkg::fclass_t  class_o
);

  logic                  sign;
  fpu_fmt_pkg::fp_exp_t  exp_f;
  fpu_fmt_pkg::fp_mant_t mant_f;
  logic                  exp_zero;
  logic                  exp_ones;
  logic                  mant_zero;

  assign sign   = rs1_i[`FPU_INT_XLEN-1];
  assign exp_f  = rs1_i[`FPU_INT_MANT_BITS +: `FPU_INT_EXP_BITS];
  assign mant_f = rs1_i[`FPU_INT_MANT_BITS-1:0];

  assign exp_zero  = (exp_f == '0);
  assign exp_ones  = (exp_f == '1);
  assign mant_zero = (mant_f == '0);

  always_comb begin
    class_o    = '0;
    class_o[0] = sign & exp_ones & mant_zero;
    class_o[1] = sign & !exp_zero & !exp_ones;
    class_o[2] = sign & exp_zero & !mant_zero;
    class_o[3] = sign & exp_zero & mant_zero;
    class_o[4] = !sign & exp_zero & mant_zero;
    class_o[5] = !sign & exp_zero & !mant_zero;
    class_o[6] = !sign & !exp_zero & !exp_ones;
    class_o[7] = !sign & exp_ones & mant_zero;
    // Quiet bit is the top fraction bit
    class_o[8] = exp_ones & !mant_zero & !mant_f[`FPU_INT_MANT_BITS-1];
    class_o[9] = exp_ones & mant_f[`FPU_INT_MANT_BITS-1];
  end

endmodule

`default_nettype wire

// ==== hdl/fpu_int_compare.sv ====
// FEQ quiet and FLT/FLE signaling compare on raw binary32 bits
// Result is 0 for any NaN, invalid is 0 for non-compare ops
`timescale 1ns/10ps
`default_nettype none

`include "fpu_int_macros.svh"

module fpu_int_compare (
  input  fpu_fmt_pkg::fp_word_t       rs1_i,
  input  fpu_fmt_pkg::fp_word_t       rs2_i,
  input  fpu_int_op_pkg::fpu_int_op_e op_i,
  output logic                        result_o,
  output logic                        invalid_o
);

  localparam int MAG_BITS = `FPU_INT_XLEN - 1;

  logic                a_nan, b_nan;
  logic                a_snan, b_snan;
  logic [MAG_BITS-1:0] a_mag, b_mag;
  logic                a_sign, b_sign;
  logic                both_zero;
  logic                eq, lt;

  assign a_sign = rs1_i[MAG_BITS];
  assign b_sign = rs2_i[MAG_BITS];
  assign a_mag  = rs1_i[MAG_BITS-1:0];
  assign b_mag  = rs2_i[MAG_BITS-1:0];

  assign a_nan  = (a_mag[MAG_BITS-1 -: `FPU_INT_EXP_BITS] == '1) &&
                  (a_mag[`FPU_INT_MANT_BITS-1:0] != '0);
  assign b_nan  = (b_mag[MAG_BITS-1 -: `FPU_INT_EXP_BITS] == '1) &&
                  (b_mag[`FPU_INT_MANT_BITS-1:0] != '0);
  assign a_snan = a_nan & !a_mag[`FPU_INT_MANT_BITS-1];
  assign b_snan = b_nan & !b_mag[`FPU_INT_MANT_BITS-1];

  // +0 and -0 compare equal
  assign both_zero = (a_mag == '0) && (b_mag == '0);
  assign eq = both_zero || (rs1_i == rs2_i);

  always_comb begin
    if (a_sign != b_sign) begin
      lt = a_sign & !both_zero;
    end else if (a_sign) begin
      lt = (a_mag > b_mag);
    end else begin
      lt = (a_mag < b_mag);
    end
  end

  always_comb begin
    result_o  = 1'b0;
    invalid_o = 1'b0;
    case (op_i)
      fpu_int_op_pkg::FEQ: begin
        result_o  = !(a_nan | b_nan) & eq;
        invalid_o = a_snan | b_snan;
      end
      fpu_int_op_pkg::FLT: begin
        result_o  = !(a_nan | b_nan) & lt;
        invalid_o = a_nan | b_nan;
      end
      fpu_int_op_pkg::FLE: begin
        result_o  = !(a_nan | b_nan) & (lt | eq);
        invalid_o = a_nan | b_nan;
      end
      default: ;
    endcase
  end

endmodule

`default_nettype wire

// ==== hdl/fpu_int_ctrl.sv ====
// Sequencer, start is only seen in IDLE
// Convert loads in the start cycle, shifts until the counter empties
`timescale 1ns/10ps
`default_nettype none

module fpu_int_ctrl (
  input  logic                        clk_i,
  input  logic                        rst_n_i,
  input  logic                        start_i,
  input  fpu_int_op_pkg::fpu_int_op_e op_i,
  input  logic                        cnt_zero_i,
  output logic                        busy_o,
  output logic                        cnt_load_o,
  output logic                        f2i_load_o,
  output logic                        shift_o,
  output logic                        round_o,
  output logic                        result_we_o
);

  fpu_int_op_pkg::ctrl_state_e state_q, state_n;
  logic is_cvt;

  assign is_cvt = (op_i == fpu_int_op_pkg::FCVT_W) || (op_i == fpu_int_op_pkg::FCVT_WU);

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      state_q <= fpu_int_op_pkg::IDLE;
    end else begin
      state_q <= state_n;
    end
  end

  always_comb begin
    state_n     = state_q;
    cnt_load_o  = 1'b0;
    shift_o     = 1'b0;
    round_o     = 1'b0;
    result_we_o = 1'b0;
    case (state_q)
      fpu_int_op_pkg::IDLE: begin
        if (start_i) begin
          cnt_load_o = is_cvt;
          state_n    = is_cvt ? fpu_int_op_pkg::SHIFT : fpu_int_op_pkg::DONE;
        end
      end
      fpu_int_op_pkg::SHIFT: begin
        shift_o = !cnt_zero_i;
        if (cnt_zero_i) begin
          state_n = fpu_int_op_pkg::ROUND;
        end
      end
      fpu_int_op_pkg::ROUND: begin
        round_o = 1'b1;
        state_n = fpu_int_op_pkg::DONE;
      end
      default: begin
        result_we_o = 1'b1;
        state_n     = fpu_int_op_pkg::IDLE;
      end
    endcase
  end

  // Counter and converter load together
  assign f2i_load_o = cnt_load_o;
  assign busy_o     = (state_q != fpu_int_op_pkg::IDLE);

endmodule

`default_nettype wire

// ==== hdl/fpu_int_f2i.sv ====
// Serial float to int, one bit per shift, magnitudes of 2^31 and up saturate
// Hidden bit loads at weight 2^30, so at most 32 shift steps
`timescale 1ns/10ps
`default_nettype none

`include "fpu_int_macros.svh"

module fpu_int_f2i (
  input  logic                      clk_i,
  input  logic                      rst_n_i,
  input  logic                      load_i,
  input  logic                      shift_i,
  input  logic                      round_i,
  input  fpu_fmt_pkg::fp_word_t     rs1_i,
  input  fpu_int_op_pkg::frm_e      rm_i,
  input  logic                      signed_i,
  output fpu_fmt_pkg::shift_cnt_t   count_o,
  output fpu_fmt_pkg::int_word_t    result_o,
  output fpu_int_op_pkg::fflags_t   fflags_o
);

  localparam int XL = `FPU_INT_XLEN;
  // Biased exponent where the hidden bit already sits at 2^30
  localparam int EXP_TOP = `FPU_INT_BIAS + XL - 2;

  fpu_fmt_pkg::fp_exp_t  exp_f;
  logic [7:0]            diff;
  logic [XL+1:0]         sig_q;
  logic                  sticky_q, sign_q, nan_q, big_q, ge_one_q;
  logic                  lsb, guard, sticky, inc, oor;
  logic [XL:0]           mag;
  fpu_fmt_pkg::int_word_t res_n;
  fpu_int_op_pkg::fflags_t flags_n;

  assign exp_f = rs1_i[`FPU_INT_MANT_BITS +: `FPU_INT_EXP_BITS];
  assign diff  = 8'(EXP_TOP) - exp_f;

  always_comb begin
    if (exp_f >= EXP_TOP) begin
      count_o = '0;
    end else if (diff > 8'd32) begin
      count_o = 6'd32;
    end else begin
      count_o = diff[`FPU_INT_CNT_BITS-1:0];
    end
  end

  // Control and flag state
  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      sticky_q <= 1'b0;
      sign_q   <= 1'b0;
      nan_q    <= 1'b0;
      big_q    <= 1'b0;
      ge_one_q <= 1'b0;
      fflags_o <= '0;
    end else if (load_i) begin
      sticky_q <= 1'b0;
      sign_q   <= rs1_i[XL-1];
      nan_q    <= (exp_f == '1) && (rs1_i[`FPU_INT_MANT_BITS-1:0] != '0);
      // Infinity lands here too
      big_q    <= (exp_f > EXP_TOP);
      ge_one_q <= (exp_f >= `FPU_INT_BIAS);
    end else if (shift_i) begin
      sticky_q <= sticky_q | sig_q[0];
    end else if (round_i) begin
      fflags_o <= flags_n;
    end
  end

  always_ff @(posedge clk_i) begin
    if (load_i) begin
      sig_q <= {1'b0, (exp_f != '0), rs1_i[`FPU_INT_MANT_BITS-1:0], 9'b0};
    end else if (shift_i) begin
      sig_q <= {1'b0, sig_q[XL+1:1]};
    end
    if (round_i) begin
      result_o <= res_n;
    end
  end

  assign lsb    = sig_q[2];
  assign guard  = sig_q[1];
  assign sticky = sig_q[0] | sticky_q;

  always_comb begin
    case (rm_i)
      fpu_int_op_pkg::RNE: inc = guard & (sticky | lsb);
      fpu_int_op_pkg::RDN: inc = sign_q & (guard | sticky);
      fpu_int_op_pkg::RUP: inc = !sign_q & (guard | sticky);
      fpu_int_op_pkg::RMM: inc = guard;
      default:             inc = 1'b0;
    endcase
  end

  assign mag = {1'b0, sig_q[XL+1:2]} + (XL+1)'(inc);

  always_comb begin
    if (nan_q || big_q) begin
      oor = 1'b1;
    end else if (signed_i) begin
      // -2^31 still fits
      oor = sign_q ? (mag > {1'b0, `FPU_INT_INT_MIN}) : (mag > {1'b0, `FPU_INT_INT_MAX});
    end else begin
      // Negative input that rounds to zero is fine
      oor = sign_q & (ge_one_q | (mag != '0));
    end

    if (!oor) begin
      res_n = sign_q ? (~mag[XL-1:0] + 1'b1) : mag[XL-1:0];
    end else if (nan_q || !sign_q) begin
      res_n = signed_i ? `FPU_INT_INT_MAX : `FPU_INT_UINT_MAX;
    end else begin
      res_n = signed_i ? `FPU_INT_INT_MIN : '0;
    end

    flags_n = '0;
    flags_n[`FPU_INT_NV] = oor;
    flags_n[`FPU_INT_NX] = !oor & (guard | sticky);
  end

endmodule

`default_nettype wire

// ==== hdl/fpu_int_macros.svh ====
// Fixed binary32 layout and XLEN 32 limits used by every block
// Flag positions follow the RISC-V fflags CSR order
`ifndef FPU_INT_MACROS_SVH
`define FPU_INT_MACROS_SVH

`define FPU_INT_XLEN      32
`define FPU_INT_EXP_BITS  8
`define FPU_INT_MANT_BITS 23
`define FPU_INT_BIAS      127
`define FPU_INT_CNT_BITS  6

`define FPU_INT_NV 4
`define FPU_INT_DZ 3
`define FPU_INT_OF 2
`define FPU_INT_UF 1
`define FPU_INT_NX 0

`define FPU_INT_INT_MAX  32'h7fff_ffff
`define FPU_INT_INT_MIN  32'h8000_0000
`define FPU_INT_UINT_MAX 32'hffff_ffff

`endif

// ==== hdl/fpu_int_op_pkg.sv ====
// Operation, rounding mode and control encodings
// frm_e uses the RISC-V frm values, dynamic rounding is not decoded
`default_nettype none

package fpu_int_op_pkg;

  typedef enum logic [2:0] {
    FEQ     = 3'd0,
    FLT     = 3'd1,
    FLE     = 3'd2,
    FCVT_W  = 3'd3,
    FCVT_WU = 3'd4,
    FCLASS  = 3'd5,
    FMV     = 3'd6
  } fpu_int_op_e;

  typedef enum logic [2:0] {
    RNE = 3'd0,
    RTZ = 3'd1,
    RDN = 3'd2,
    RUP = 3'd3,
    RMM = 3'd4
  } frm_e;

  typedef enum logic [1:0] {
    IDLE,
    SHIFT,
    ROUND,
    DONE
  } ctrl_state_e;

  // NV DZ OF UF NX
  typedef logic [4:0] fflags_t;

endpackage

`default_nettype wire

// ==== hdl/fpu_int_step_counter.sv ====
// Shift step counter, load wins over step, holds at zero
`timescale 1ns/10ps
`default_nettype none

module fpu_int_step_counter (
  input  logic                      clk_i,
  input  logic                      rst_n_i,
  input  logic                      load_i,
  input  fpu_fmt_pkg::shift_cnt_t   count_i,
  input  logic                      step_i,
  output logic                      zero_o
);

  fpu_fmt_pkg::shift_cnt_t cnt_q;

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      cnt_q <= '0;
    end else if (load_i) begin
      cnt_q <= count_i;
    end else if (step_i && (cnt_q != '0)) begin
      cnt_q <= cnt_q - 1'b1;
    end
  end

  assign zero_o = (cnt_q == '0);

endmodule

`default_nettype wire

// ==== hdl/fpu_int_top.sv ====
// Integer writeback FPU, strobe interface without back-pressure
// Result and flags hold from done until the next accepted start
`timescale 1ns/10ps
`default_nettype none

`include "fpu_int_macros.svh"

module fpu_int_top (
  input  logic                        clk_i,
  input  logic                        rst_n_i,
  input  logic                        start_i,
  input  fpu_int_op_pkg::fpu_int_op_e op_i,
  input  fpu_int_op_pkg::frm_e        rm_i,
  input  fpu_fmt_pkg::fp_word_t       rs1_i,
  input  fpu_fmt_pkg::fp_word_t       rs2_i,
  output logic                        busy_o,
  output logic                        done_o,
  output fpu_fmt_pkg::int_word_t      result_o,
  output fpu_int_op_pkg::fflags_t     fflags_o
);

  fpu_int_op_pkg::fpu_int_op_e op_q;
  fpu_int_op_pkg::frm_e        rm_q;
  fpu_fmt_pkg::fp_word_t       rs1_q, rs2_q;
  fpu_fmt_pkg::shift_cnt_t     f2i_count;
  fpu_fmt_pkg::int_word_t      f2i_result, result_n;
  fpu_int_op_pkg::fflags_t     f2i_fflags, fflags_n;
  fpu_fmt_pkg::fclass_t        class_mask;
  logic cnt_load, f2i_load, shift_en, round_en, result_we, cnt_zero;
  logic cmp_result, cmp_invalid;

  always_ff @(posedge clk_i) begin
    if (start_i && !busy_o) begin
      op_q  <= op_i;
      rm_q  <= rm_i;
      rs1_q <= rs1_i;
      rs2_q <= rs2_i;
    end
  end

  fpu_int_ctrl ctrl_i (
    .clk_i, .rst_n_i, .start_i, .op_i,
    .cnt_zero_i  (cnt_zero),
    .busy_o,
    .cnt_load_o  (cnt_load),
    .f2i_load_o  (f2i_load),
    .shift_o     (shift_en),
    .round_o     (round_en),
    .result_we_o (result_we)
  );

  fpu_int_step_counter cnt_i (
    .clk_i, .rst_n_i,
    .load_i  (cnt_load),
    .count_i (f2i_count),
    .step_i  (shift_en),
    .zero_o  (cnt_zero)
  );

  // Loads from the live operand in the start cycle
  fpu_int_f2i f2i_i (
    .clk_i, .rst_n_i,
    .load_i   (f2i_load),
    .shift_i  (shift_en),
    .round_i  (round_en),
    .rs1_i    (rs1_i),
    .rm_i     (rm_q),
    .signed_i (op_q == fpu_int_op_pkg::FCVT_W),
    .count_o  (f2i_count),
    .result_o (f2i_result),
    .fflags_o (f2i_fflags)
  );

  fpu_int_compare cmp_i (
    .rs1_i (rs1_q), .rs2_i (rs2_q), .op_i (op_q),
    .result_o (cmp_result), .invalid_o (cmp_invalid)
  );

  fpu_int_classify cls_i (.rs1_i (rs1_q), .class_o (class_mask));

  always_comb begin
    result_n = rs1_q;
    fflags_n = '0;
    case (op_q)
      fpu_int_op_pkg::FEQ, fpu_int_op_pkg::FLT, fpu_int_op_pkg::FLE: begin
        result_n = {{(`FPU_INT_XLEN-1){1'b0}}, cmp_result};
        fflags_n[`FPU_INT_NV] = cmp_invalid;
      end
      fpu_int_op_pkg::FCVT_W, fpu_int_op_pkg::FCVT_WU: begin
        result_n = f2i_result;
        fflags_n = f2i_fflags;
      end
      fpu_int_op_pkg::FCLASS: result_n = {{(`FPU_INT_XLEN-10){1'b0}}, class_mask};
      default: ;
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      done_o   <= 1'b0;
      result_o <= '0;
      fflags_o <= '0;
    end else begin
      done_o <= result_we;
      if (result_we) begin
        result_o <= result_n;
        fflags_o <= fflags_n;
      end
    end
  end

endmodule

`default_nettype wire
